// ==== build.f ====
rtl/vldu_pkg.sv
rtl/vldu_insn_queue.sv
rtl/vldu_beat_packer.sv
rtl/vldu_result_queue.sv
rtl/vldu_top.sv
bench/tb_clock_gen.sv
bench/tb_vldu.sv

// ==== Makefile ====
# Verilator build and run of the vector load unit testbench

TOP := tb_vldu
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) \
		-Mdir $(OBJ) -o V$(TOP)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

// ==== bench/tb_vldu.sv ====
////////////////////
// Testbench of the vector load unit with default parameters
// Beats are aligned to each instruction and sent in acceptance order
// Handshakes are sampled at the falling edge, inputs change 1 ns after the rising edge
////////////////////

`timescale 1ns/1ps

module tb_vldu;

  import vldu_pkg::*;

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned BeatBytes    = AxiDataWidth / 8;
  localparam int unsigned WordBytes    = NrLanes * ElenBytes;

  // Instructions per test, the watchdog budget follows from them
  localparam int unsigned NrBackToBack   = 6;
  localparam int unsigned NrWithhold     = 8;
  localparam int unsigned NrRandom       = 20;
  localparam int unsigned NrInsnTotal    = 2 + NrBackToBack + NrWithhold + NrRandom;
  localparam int unsigned WatchdogCycles = 200 * NrInsnTotal;

  logic clk_i;
  logic rst_ni;

  vldu_req_t                  pe_req_i;
  logic                       pe_req_valid_i;
  logic                       pe_req_ready_o;
  logic [AxiDataWidth-1:0]    axi_r_data_i;
  logic                       axi_r_valid_i;
  logic                       axi_r_ready_o;
  lane_result_t [NrLanes-1:0] ldu_result_o;
  logic [NrLanes-1:0]         ldu_result_req_o;
  logic [NrLanes-1:0]         ldu_result_gnt_i;
  logic [NrVInsn-1:0]         vinsn_done_o;
  logic                       load_complete_o;

  ////////////////////
  // Bench state

  integer seed;
  string  test_name;

  // Pending stimulus
  vldu_req_t               send_q [$];
  logic [AxiDataWidth-1:0] beat_q [$];
  // Byte streams of all instructions, back to back
  logic [7:0]              stream_q [$];

  // Expected lane writes, done ids, and results owed before each done
  lane_result_t exp_q [NrLanes][$];
  vid_t         done_q [$];
  int unsigned  done_total_q [$];

  int unsigned total_results;
  int unsigned granted_total;
  int          pending;
  int unsigned full_cycles;
  vid_t        next_id;

  logic req_fire;
  logic beat_fire;
  logic grant_random;
  logic beat_gaps;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  vldu_top #(
    .NrLanes      (NrLanes),
    .AxiDataWidth (AxiDataWidth)
  ) dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .pe_req_i         (pe_req_i),
    .pe_req_valid_i   (pe_req_valid_i),
    .pe_req_ready_o   (pe_req_ready_o),
    .axi_r_data_i     (axi_r_data_i),
    .axi_r_valid_i    (axi_r_valid_i),
    .axi_r_ready_o    (axi_r_ready_o),
    .ldu_result_o     (ldu_result_o),
    .ldu_result_req_o (ldu_result_req_o),
    .ldu_result_gnt_i (ldu_result_gnt_i),
    .vinsn_done_o     (vinsn_done_o),
    .load_complete_o  (load_complete_o)
  );

  ////////////////////
  // Reference and checks

  // Word byte b lands in lane b/8, byte b%8, at address vd*32 + word
  function automatic lane_result_t ref_result(vldu_req_t req, int unsigned base,
                                              int unsigned word, int unsigned lane);
    lane_result_t res;
    int unsigned  nbytes;
    int unsigned  pos;
    nbytes    = 32'(req.vl) << req.vsew;
    res.id    = req.id;
    res.addr  = vaddr_t'(32'(req.vd) * 32 + word);
    res.wdata = '0;
    res.be    = '0;
    for (int unsigned b = 0; b < ElenBytes; b++) begin
      pos = word * WordBytes + lane * ElenBytes + b;
      // Bytes past the end stay disabled and zero
      if (pos < nbytes) begin
        res.wdata[8*b +: 8] = stream_q[base + pos];
        res.be[b]           = 1'b1;
      end
    end
    return res;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check_result(input string name, input lane_result_t exp,
                              input lane_result_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      fail_run("Lane result mismatch");
    end
  endtask

  task automatic check_done(input string name, input vid_t exp, input vid_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected done id %0d, actual %0d", name, exp, act);
      fail_run("Done id out of order");
    end
  endtask

  // Single-bit control outputs
  task automatic check_flag(input string name, input string sig_name, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %s %b, actual %b", name, sig_name, exp, act);
      fail_run("Control output has the wrong value");
    end
  endtask

  ////////////////////
  // Stimulus building

  // Queues one load with its beats and all expected lane writes
  task automatic queue_load(input vreg_t vd, input vlen_t vl, input vsew_e vsew);
    vldu_req_t               req;
    logic [AxiDataWidth-1:0] beat;
    int unsigned             nbytes;
    int unsigned             base;
    int unsigned             nbeats;
    int unsigned             nwords;
    int unsigned             pos;
    req.id   = next_id;
    req.vd   = vd;
    req.vl   = vl;
    req.vsew = vsew;
    next_id  = next_id + 1'b1;
    nbytes   = 32'(vl) << vsew;
    base     = stream_q.size();
    for (int unsigned i = 0; i < nbytes; i++) begin
      stream_q.push_back(8'($random(seed)));
    end
    // Unused bytes of the last beat carry junk
    nbeats = (nbytes + BeatBytes - 1) / BeatBytes;
    for (int unsigned j = 0; j < nbeats; j++) begin
      for (int unsigned i = 0; i < BeatBytes; i++) begin
        pos              = j * BeatBytes + i;
        beat[8*i +: 8]   = (pos < nbytes) ? stream_q[base + pos] : 8'($random(seed));
      end
      beat_q.push_back(beat);
    end
    nwords = (nbytes + WordBytes - 1) / WordBytes;
    for (int unsigned k = 0; k < nwords; k++) begin
      for (int unsigned lane = 0; lane < NrLanes; lane++) begin
        exp_q[lane].push_back(ref_result(req, base, k, lane));
      end
    end
    total_results = total_results + nwords * NrLanes;
    done_q.push_back(req.id);
    done_total_q.push_back(total_results);
    send_q.push_back(req);
  endtask

  // Random width, length up to 256 bytes, random destination
  task automatic queue_random_load();
    vsew_e       vsew;
    int unsigned max_vl;
    vlen_t       vl;
    vreg_t       vd;
    vsew   = vsew_e'($unsigned($random(seed)) % 4);
    max_vl = 256 >> vsew;
    vl     = vlen_t'(1 + $unsigned($random(seed)) % max_vl);
    vd     = vreg_t'($unsigned($random(seed)) % 32);
    queue_load(vd, vl, vsew);
  endtask

  // Wait on completion, the watchdog bounds it
  // Queues only change away from the rising edge, so the test resumes on one
  task automatic wait_idle();
    while (done_q.size() != 0 || send_q.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  ////////////////////
  // Input drivers

  initial begin : drive_inputs
    pe_req_i         = '0;
    pe_req_valid_i   = 1'b0;
    axi_r_data_i     = '0;
    axi_r_valid_i    = 1'b0;
    ldu_result_gnt_i = '0;
    req_fire         = 1'b0;
    beat_fire        = 1'b0;
    grant_random     = 1'b0;
    beat_gaps        = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      // Sequencer keeps valid up until accepted
      if (req_fire) begin
        void'(send_q.pop_front());
      end
      pe_req_valid_i = (send_q.size() != 0);
      pe_req_i       = (send_q.size() != 0) ? send_q[0] : '0;

      // A beat offered stays until taken
      if (beat_fire) begin
        void'(beat_q.pop_front());
      end
      if (!(axi_r_valid_i && !beat_fire)) begin
        axi_r_valid_i = (beat_q.size() != 0) &&
                        (!beat_gaps || ($random(seed) & 3) != 0);
      end
      axi_r_data_i = (beat_q.size() != 0) ? beat_q[0] : '0;

      ldu_result_gnt_i = grant_random ? NrLanes'($random(seed)) : '1;
    end
  end

  ////////////////////
  // Compare process

  always @(negedge clk_i) begin : compare_outputs
    vid_t        done_id;
    int unsigned owed;
    done_id = '0;
    owed    = 0;
    if (rst_ni) begin
      beat_fire = axi_r_valid_i && axi_r_ready_o;

      for (int unsigned lane = 0; lane < NrLanes; lane++) begin
        if (ldu_result_req_o[lane] && ldu_result_gnt_i[lane]) begin
          if (exp_q[lane].size() == 0) begin
            fail_run($sformatf("Lane %0d wrote a result that was not expected", lane));
          end
          check_result(test_name, exp_q[lane].pop_front(), ldu_result_o[lane]);
          granted_total = granted_total + 1;
        end
      end

      // Done pulse first, the queue slot is already free this cycle
      if (vinsn_done_o != '0 || load_complete_o) begin
        check_flag(test_name, "load_complete_o", 1'b1, load_complete_o);
        if ($countones(vinsn_done_o) != 1) begin
          fail_run("vinsn_done_o is not one-hot while load_complete_o is high");
        end
        if (done_q.size() == 0) begin
          fail_run("Done pulse arrived with no instruction outstanding");
        end
        for (int i = 0; i < NrVInsn; i++) begin
          if (vinsn_done_o[i]) begin
            done_id = vid_t'(i);
          end
        end
        check_done(test_name, done_q.pop_front(), done_id);
        owed = done_total_q.pop_front();
        if (granted_total < owed) begin
          fail_run("Done pulse came before all results of the instruction were written");
        end
        pending = pending - 1;
      end

      check_flag(test_name, "pe_req_ready_o", pending != int'(VInsnQueueDepth),
                 pe_req_ready_o);
      if (pending == int'(VInsnQueueDepth)) begin
        full_cycles = full_cycles + 1;
      end

      req_fire = pe_req_valid_i && pe_req_ready_o;
      if (req_fire) begin
        pending = pending + 1;
      end
    end
  end

  ////////////////////
  // Watchdog

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Run timed out waiting for completion after %0d cycles", WatchdogCycles);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // Test sequence

  initial begin : stimulus
    logic leftover;
    seed          = 58;
    test_name     = "reset";
    total_results = 0;
    granted_total = 0;
    pending       = 0;
    full_cycles   = 0;
    next_id       = '0;
    leftover      = 1'b0;

    @(posedge rst_ni);
    @(negedge clk_i);
    check_flag(test_name, "pe_req_ready_o", 1'b1, pe_req_ready_o);
    check_flag(test_name, "axi_r_ready_o", 1'b0, axi_r_ready_o);
    check_flag(test_name, "load_complete_o", 1'b0, load_complete_o);
    check_flag(test_name, "any ldu_result_req_o", 1'b0, |ldu_result_req_o);
    check_flag(test_name, "any vinsn_done_o", 1'b0, |vinsn_done_o);
    @(posedge clk_i);

    // Four full words
    test_name = "single_ew64";
    queue_load(5'd2, 16'd16, EW64);
    wait_idle();

    // 13 bytes, short last beat and short word
    test_name = "partial_ew8";
    queue_load(5'd7, 16'd13, EW8);
    wait_idle();

    test_name   = "back_to_back";
    full_cycles = 0;
    for (int i = 0; i < NrBackToBack; i++) begin
      queue_load(vreg_t'(3 * i + 1), vlen_t'(8 + 5 * i), vsew_e'(i % 4));
    end
    wait_idle();
    if (full_cycles == 0) begin
      fail_run("Instruction queue never filled during back_to_back");
    end

    test_name    = "grant_withhold";
    grant_random = 1'b1;
    for (int i = 0; i < NrWithhold; i++) begin
      queue_random_load();
    end
    wait_idle();

    test_name = "random_mix";
    beat_gaps = 1'b1;
    for (int i = 0; i < NrRandom; i++) begin
      queue_random_load();
    end
    wait_idle();

    for (int unsigned lane = 0; lane < NrLanes; lane++) begin
      if (exp_q[lane].size() != 0) begin
        leftover = 1'b1;
      end
    end
    if (leftover || beat_q.size() != 0) begin
      $display("Expected results or beats were left over at the end");
      $display("TEST FAIL");
      $fatal(1, "run ended with leftovers");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
////////////////////
// 10 ns clock, reset held low for three rising edges
// Reset releases 1 ns after the third edge
////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== rtl/vldu_top.sv ====
////////////////////
// Vector load unit, top level
// NrLanes*8 must be a multiple of AxiDataWidth/8
// Masks, vstart and address generation are not supported
////////////////////

`timescale 1ns/1ps

module vldu_top #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned AxiDataWidth = 64
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Sequencer
  input  vldu_pkg::vldu_req_t                   pe_req_i,
  input  logic                                  pe_req_valid_i,
  output logic                                  pe_req_ready_o,
  // Memory read data
  input  logic [AxiDataWidth-1:0]               axi_r_data_i,
  input  logic                                  axi_r_valid_i,
  output logic                                  axi_r_ready_o,
  // Lanes
  output vldu_pkg::lane_result_t [NrLanes-1:0]  ldu_result_o,
  output logic [NrLanes-1:0]                    ldu_result_req_o,
  input  logic [NrLanes-1:0]                    ldu_result_gnt_i,
  // Completion
  output logic [vldu_pkg::NrVInsn-1:0]          vinsn_done_o,
  output logic                                  load_complete_o
);

  import vldu_pkg::*;

  // Issue handshake
  vldu_req_t issue_req;
  logic      issue_valid;
  logic      issue_done;

  // Packer to result queue
  lane_result_t [NrLanes-1:0] word_data;
  logic                       word_last;
  logic                       word_push;
  logic                       result_full;

  // Last word retired
  logic commit_done;

  ////////////////////
  // Configuration

  vldu_insn_queue i_insn_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .pe_req_ready_o  (pe_req_ready_o),
    .issue_req_o     (issue_req),
    .issue_valid_o   (issue_valid),
    .issue_done_i    (issue_done),
    .commit_done_i   (commit_done),
    .vinsn_done_o    (vinsn_done_o),
    .load_complete_o (load_complete_o)
  );

  ////////////////////
  // Datapath

  vldu_beat_packer #(
    .NrLanes      (NrLanes),
    .AxiDataWidth (AxiDataWidth)
  ) i_beat_packer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_req_i    (issue_req),
    .issue_valid_i  (issue_valid),
    .issue_done_o   (issue_done),
    .axi_r_data_i   (axi_r_data_i),
    .axi_r_valid_i  (axi_r_valid_i),
    .axi_r_ready_o  (axi_r_ready_o),
    .result_full_i  (result_full),
    .word_o         (word_data),
    .word_last_o    (word_last),
    .word_push_o    (word_push)
  );

  vldu_result_queue #(
    .NrLanes (NrLanes)
  ) i_result_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .word_i           (word_data),
    .word_last_i      (word_last),
    .word_push_i      (word_push),
    .result_full_o    (result_full),
    .ldu_result_o     (ldu_result_o),
    .ldu_result_req_o (ldu_result_req_o),
    .ldu_result_gnt_i (ldu_result_gnt_i),
    .commit_done_o    (commit_done)
  );

endmodule

// ==== rtl/vldu_result_queue.sv ====
////////////////////
// Two-entry result buffer, one slot per lane in each entry
// Lanes drain independently by request/grant
// The entry retires once every lane has been granted
////////////////////

`timescale 1ns/1ps

module vldu_result_queue #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // From the packer
  input  vldu_pkg::lane_result_t [NrLanes-1:0]  word_i,
  input  logic                                  word_last_i,
  input  logic                                  word_push_i,
  output logic                                  result_full_o,
  // Lane write ports
  output vldu_pkg::lane_result_t [NrLanes-1:0]  ldu_result_o,
  output logic [NrLanes-1:0]                    ldu_result_req_o,
  input  logic [NrLanes-1:0]                    ldu_result_gnt_i,
  // Last word of an instruction retired
  output logic                                  commit_done_o
);

  import vldu_pkg::*;

  localparam int unsigned PntW = $clog2(ResultQueueDepth);
  localparam int unsigned CntW = $clog2(ResultQueueDepth + 1);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [CntW-1:0] cnt_t;

  function automatic pnt_t next_pnt(pnt_t pnt);
    if (pnt == pnt_t'(ResultQueueDepth - 1)) begin
      return '0;
    end
    return pnt + 1'b1;
  endfunction

  ////////////////////
  // Storage

  lane_result_t [NrLanes-1:0] data_q [ResultQueueDepth];
  logic         [NrLanes-1:0] valid_d [ResultQueueDepth];
  logic         [NrLanes-1:0] valid_q [ResultQueueDepth];
  logic                       last_q [ResultQueueDepth];

  pnt_t rd_pnt_d, rd_pnt_q;
  pnt_t wr_pnt_d, wr_pnt_q;
  cnt_t cnt_d, cnt_q;

  logic push;
  logic retire;

  assign result_full_o = (cnt_q == cnt_t'(ResultQueueDepth));
  assign push          = word_push_i && !result_full_o;

  // Head entry goes out to the lanes
  assign ldu_result_o     = data_q[rd_pnt_q];
  assign ldu_result_req_o = valid_q[rd_pnt_q];

  always_comb begin
    valid_d  = valid_q;
    rd_pnt_d = rd_pnt_q;
    wr_pnt_d = wr_pnt_q;

    // A grant clears only its own lane
    valid_d[rd_pnt_q] = valid_q[rd_pnt_q] & ~ldu_result_gnt_i;

    // Retire the head when no lane still waits
    retire        = (cnt_q != '0) && (valid_d[rd_pnt_q] == '0);
    commit_done_o = retire && last_q[rd_pnt_q];
    if (retire) begin
      rd_pnt_d = next_pnt(rd_pnt_q);
    end

    // New word requests every lane
    if (push) begin
      valid_d[wr_pnt_q] = '1;
      wr_pnt_d          = next_pnt(wr_pnt_q);
    end

    cnt_d = cnt_q + cnt_t'(push) - cnt_t'(retire);
  end

  ////////////////////
  // Registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned e = 0; e < ResultQueueDepth; e++) begin
        valid_q[e] <= '0;
      end
      rd_pnt_q <= '0;
      wr_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      rd_pnt_q <= rd_pnt_d;
      wr_pnt_q <= wr_pnt_d;
      cnt_q    <= cnt_d;
    end
  end

  // Payload and last flag
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[wr_pnt_q] <= word_i;
      last_q[wr_pnt_q] <= word_last_i;
    end
  end

endmodule

// ==== rtl/vldu_beat_packer.sv ====
////////////////////
// Packs read beats into lane-striped register words
// Beats must be in order and aligned to the instruction start
// Word size NrLanes*8 must be a multiple of the beat size
////////////////////

`timescale 1ns/1ps

module vldu_beat_packer #(
  parameter int unsigned NrLanes      = 4,
  parameter int unsigned AxiDataWidth = 64
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Issuing instruction
  input  vldu_pkg::vldu_req_t                      issue_req_i,
  input  logic                                     issue_valid_i,
  output logic                                     issue_done_o,
  // Read data channel
  input  logic [AxiDataWidth-1:0]                  axi_r_data_i,
  input  logic                                     axi_r_valid_i,
  output logic                                     axi_r_ready_o,
  // Towards the result queue
  input  logic                                     result_full_i,
  output vldu_pkg::lane_result_t [NrLanes-1:0]     word_o,
  output logic                                     word_last_o,
  output logic                                     word_push_o
);

  import vldu_pkg::*;

  localparam int unsigned BeatBytes = AxiDataWidth / 8;
  localparam int unsigned WordBytes = NrLanes * ElenBytes;
  localparam int unsigned BeatPntW  = $clog2(BeatBytes) + 1;
  localparam int unsigned WordPntW  = $clog2(WordBytes) + 1;
  // 32 words per register and lane
  localparam int unsigned VregWordsLog2 = 5;

  typedef logic [BeatPntW-1:0] beat_pnt_t;
  typedef logic [WordPntW-1:0] word_pnt_t;

  packer_state_e state_d, state_q;

  // Byte position in the current beat and in the current word
  beat_pnt_t beat_pnt_d, beat_pnt_q;
  word_pnt_t word_pnt_d, word_pnt_q;
  // Instruction bytes not yet copied
  vlen_t     bytes_left_d, bytes_left_q;
  // Word index within the instruction
  vaddr_t    word_idx_d, word_idx_q;

  // Partially assembled word
  lane_result_t [NrLanes-1:0] word_q;

  vlen_t  beat_left;
  vlen_t  word_left;
  vlen_t  copy_bytes;
  logic   insn_end;
  logic   word_end;
  logic   beat_end;
  logic   step;
  vaddr_t word_addr;

  ////////////////////
  // Datapath

  always_comb begin
    int unsigned src_byte;

    state_d      = state_q;
    beat_pnt_d   = beat_pnt_q;
    word_pnt_d   = word_pnt_q;
    bytes_left_d = bytes_left_q;
    word_idx_d   = word_idx_q;
    word_o       = word_q;
    issue_done_o = 1'b0;
    word_push_o  = 1'b0;
    word_last_o  = 1'b0;
    src_byte     = 0;

    // Smallest of beat, word and instruction remainder
    beat_left  = vlen_t'(BeatBytes) - vlen_t'(beat_pnt_q);
    word_left  = vlen_t'(WordBytes) - vlen_t'(word_pnt_q);
    copy_bytes = (beat_left < word_left) ? beat_left : word_left;
    copy_bytes = (bytes_left_q < copy_bytes) ? bytes_left_q : copy_bytes;

    insn_end = (copy_bytes == bytes_left_q);
    word_end = (copy_bytes == word_left) || insn_end;
    beat_end = (copy_bytes == beat_left) || insn_end;

    // Same word address in every lane
    word_addr = (vaddr_t'(issue_req_i.vd) << VregWordsLog2) + word_idx_q;
    for (int unsigned lane = 0; lane < NrLanes; lane++) begin
      word_o[lane].id   = issue_req_i.id;
      word_o[lane].addr = word_addr;
    end

    // Only complete beats are acknowledged
    axi_r_ready_o = (state_q == PACK) && !result_full_i && beat_end;
    step          = (state_q == PACK) && !result_full_i && axi_r_valid_i;

    case (state_q)
      IDLE_LOAD: begin
        if (issue_valid_i) begin
          bytes_left_d = issue_req_i.vl << issue_req_i.vsew;
          beat_pnt_d   = '0;
          word_pnt_d   = '0;
          word_idx_d   = '0;
          state_d      = PACK;
        end
      end
      PACK: begin
        if (step) begin
          // Word byte w sits in lane w/8, byte w%8
          for (int unsigned w = 0; w < WordBytes; w++) begin
            if (w >= word_pnt_q && w < word_pnt_q + copy_bytes) begin
              src_byte = w - word_pnt_q + beat_pnt_q;
              word_o[w/ElenBytes].wdata[8*(w%ElenBytes) +: 8] = axi_r_data_i[8*src_byte +: 8];
              word_o[w/ElenBytes].be[w%ElenBytes]             = 1'b1;
            end
          end

          beat_pnt_d   = beat_end ? '0 : beat_pnt_q + beat_pnt_t'(copy_bytes);
          word_pnt_d   = word_end ? '0 : word_pnt_q + word_pnt_t'(copy_bytes);
          bytes_left_d = bytes_left_q - copy_bytes;

          if (word_end) begin
            word_push_o = 1'b1;
            word_last_o = insn_end;
            word_idx_d  = word_idx_q + 1'b1;
          end

          // Last word out, go fetch the next instruction
          if (insn_end) begin
            issue_done_o = 1'b1;
            word_idx_d   = '0;
            state_d      = IDLE_LOAD;
          end
        end
      end
      default: state_d = IDLE_LOAD;
    endcase
  end

  ////////////////////
  // Registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE_LOAD;
      beat_pnt_q   <= '0;
      word_pnt_q   <= '0;
      bytes_left_q <= '0;
      word_idx_q   <= '0;
      word_q       <= '0;
    end else begin
      state_q      <= state_d;
      beat_pnt_q   <= beat_pnt_d;
      word_pnt_q   <= word_pnt_d;
      bytes_left_q <= bytes_left_d;
      word_idx_q   <= word_idx_d;
      // Fresh word starts with zero data and no enables
      word_q       <= word_push_o ? '0 : word_o;
    end
  end

endmodule

// ==== rtl/vldu_insn_queue.sv ====
////////////////////
// In-order queue of load instructions
// Requests with vl of zero are not expected
// Done pulse and load_complete_o are registered, one cycle after commit
////////////////////

`timescale 1ns/1ps

module vldu_insn_queue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Sequencer side
  input  vldu_pkg::vldu_req_t           pe_req_i,
  input  logic                          pe_req_valid_i,
  output logic                          pe_req_ready_o,
  // Issue phase, towards the packer
  output vldu_pkg::vldu_req_t           issue_req_o,
  output logic                          issue_valid_o,
  input  logic                          issue_done_i,
  // Commit phase, from the result queue
  input  logic                          commit_done_i,
  output logic [vldu_pkg::NrVInsn-1:0]  vinsn_done_o,
  output logic                          load_complete_o
);

  import vldu_pkg::*;

  localparam int unsigned PntW = $clog2(VInsnQueueDepth);
  localparam int unsigned CntW = $clog2(VInsnQueueDepth + 1);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [CntW-1:0] cnt_t;

  // Circular pointer bump
  function automatic pnt_t next_pnt(pnt_t pnt);
    if (pnt == pnt_t'(VInsnQueueDepth - 1)) begin
      return '0;
    end
    return pnt + 1'b1;
  endfunction

  ////////////////////
  // State

  // Stored instructions
  vldu_req_t queue_q [VInsnQueueDepth];

  // One pointer per phase
  pnt_t accept_pnt_d, accept_pnt_q;
  pnt_t issue_pnt_d, issue_pnt_q;
  pnt_t commit_pnt_d, commit_pnt_q;

  // Instructions still to issue, and still to commit
  cnt_t issue_cnt_d, issue_cnt_q;
  cnt_t commit_cnt_d, commit_cnt_q;

  logic [NrVInsn-1:0] vinsn_done_d, vinsn_done_q;
  logic               load_complete_d, load_complete_q;

  logic accept;
  logic issue_fire;
  logic commit_valid;
  logic commit_fire;

  ////////////////////
  // Control

  // Full once every slot waits for commit
  assign pe_req_ready_o = (commit_cnt_q != cnt_t'(VInsnQueueDepth));
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  // Oldest unissued instruction
  assign issue_req_o   = queue_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_fire    = issue_done_i && issue_valid_o;

  assign commit_valid = (commit_cnt_q != '0);
  assign commit_fire  = commit_done_i && commit_valid;

  always_comb begin
    accept_pnt_d = accept ? next_pnt(accept_pnt_q) : accept_pnt_q;
    issue_pnt_d  = issue_fire ? next_pnt(issue_pnt_q) : issue_pnt_q;
    commit_pnt_d = commit_fire ? next_pnt(commit_pnt_q) : commit_pnt_q;

    // Both counters go up on accept, each drops on its own phase
    issue_cnt_d  = issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_fire);
    commit_cnt_d = commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_fire);

    // One-hot done for the retiring id
    vinsn_done_d    = '0;
    load_complete_d = 1'b0;
    if (commit_fire) begin
      vinsn_done_d[queue_q[commit_pnt_q].id] = 1'b1;
      load_complete_d                        = 1'b1;
    end
  end

  ////////////////////
  // Registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q    <= '0;
      issue_pnt_q     <= '0;
      commit_pnt_q    <= '0;
      issue_cnt_q     <= '0;
      commit_cnt_q    <= '0;
      vinsn_done_q    <= '0;
      load_complete_q <= 1'b0;
    end else begin
      accept_pnt_q    <= accept_pnt_d;
      issue_pnt_q     <= issue_pnt_d;
      commit_pnt_q    <= commit_pnt_d;
      issue_cnt_q     <= issue_cnt_d;
      commit_cnt_q    <= commit_cnt_d;
      vinsn_done_q    <= vinsn_done_d;
      load_complete_q <= load_complete_d;
    end
  end

  // Instruction storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= pe_req_i;
    end
  end

  assign vinsn_done_o    = vinsn_done_q;
  assign load_complete_o = load_complete_q;

endmodule

// ==== rtl/vldu_pkg.sv ====
////////////////////
// Widths, types and constants shared by the vector load unit
// Lane count and beat width are set at the top level, not here
// A lane word is always ElenBytes wide
////////////////////

package vldu_pkg;

  ////////////////////
  // Sizes

  // Bytes per lane word
  localparam int unsigned ElenBytes = 8;
  // Instruction ids seen by the sequencer
  localparam int unsigned NrVInsn = 8;
  // Queued load instructions
  localparam int unsigned VInsnQueueDepth = 4;
  // Result entries per lane
  localparam int unsigned ResultQueueDepth = 2;
  // Byte counter width
  localparam int unsigned VlenBits = 16;

  ////////////////////
  // Scalar types

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [4:0]                 vreg_t;
  typedef logic [VlenBits-1:0]        vlen_t;
  typedef logic [8*ElenBytes-1:0]     elen_t;
  typedef logic [ElenBytes-1:0]       strb_t;
  // Word address inside one lane register file
  typedef logic [11:0]                vaddr_t;

  // Element width, byte length is vl << vsew
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  ////////////////////
  // Bundles

  // Load instruction from the sequencer
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vlen_t vl;
    vsew_e vsew;
  } vldu_req_t;

  // One write into one lane
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } lane_result_t;

  // Packer FSM
  typedef enum logic {
    IDLE_LOAD = 1'b0,
    PACK      = 1'b1
  } packer_state_e;

endpackage
